//--- bridge_settings_regs.sv
// bridge settings register file
// decodes bridge writes into core and analogizer settings,
// pulses a core reset request and muxes the readback word

`timescale 1ns/1ps
`default_nettype none

module bridge_settings_regs (
  input  logic                          clk_74a,
  input  logic                          pll_core_locked,
  input  logic [31:0]                   bridge_addr,
  input  logic [31:0]                   bridge_wr_data,
  input  logic                          bridge_wr,
  output logic [31:0]                   bridge_rd_data,
  output pce_ctrl_pkg::core_settings_t  settings,
  output pce_ctrl_pkg::analogizer_cfg_t analog_cfg,
  output logic                          reset_request
);

  //////////////////////////////
  // write decode
  //////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings      <= '0;
      analog_cfg    <= '0;
      reset_request <= 1'b0;
    end else begin
      // one cycle pulse per write to the reset address
      reset_request <= bridge_wr && (bridge_addr == pce_ctrl_pkg::reg_reset);
      if (bridge_wr) begin
        case (bridge_addr)
          pce_ctrl_pkg::reg_sgx:
            settings.is_sgx <= bridge_wr_data[0];
          pce_ctrl_pkg::reg_turbo_tap:
            settings.turbo_tap_enable <= bridge_wr_data[0];
          pce_ctrl_pkg::reg_button6:
            settings.button6_enable <= bridge_wr_data[0];
          // turbo speeds take two bits
          pce_ctrl_pkg::reg_b1_speed:
            settings.button1_turbo_speed <= bridge_wr_data[1:0];
          pce_ctrl_pkg::reg_b2_speed:
            settings.button2_turbo_speed <= bridge_wr_data[1:0];
          // video flags
          pce_ctrl_pkg::reg_overscan:
            settings.overscan_enable <= bridge_wr_data[0];
          pce_ctrl_pkg::reg_extra_sprites:
            settings.extra_sprites_enable <= bridge_wr_data[0];
          pce_ctrl_pkg::reg_raw_rgb:
            settings.raw_rgb_enable <= bridge_wr_data[0];
          // audio boosts
          pce_ctrl_pkg::reg_master_boost:
            settings.master_audio_boost <= bridge_wr_data[1:0];
          pce_ctrl_pkg::reg_adpcm_boost:
            settings.adpcm_audio_boost <= bridge_wr_data[0];
          pce_ctrl_pkg::reg_cd_boost:
            settings.cd_audio_boost <= bridge_wr_data[0];
          // analogizer word keeps the low 14 bits
          pce_ctrl_pkg::reg_analogizer:
            analog_cfg <= pce_ctrl_pkg::analogizer_cfg_t'(bridge_wr_data[13:0]);
          // unknown addresses leave everything alone
          default: begin
          end
        endcase
      end
    end
  end

  //////////////////////////////
  // readback
  //////////////////////////////

  // everything but the analogizer word reads as zero
  always_comb begin
    bridge_rd_data = '0;
    if (bridge_addr == pce_ctrl_pkg::reg_analogizer) begin
      bridge_rd_data = 32'(analog_cfg);
    end
  end

  // request is a strict single-cycle pulse
  a_reset_request_pulse : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    reset_request |=> !reset_request
  );

endmodule

`default_nettype wire

//--- controller_router.sv
// player pad router
// per player choice between handheld pad keys and SNAC adapter
// pads, driven by the analogizer settings word, registered once

`timescale 1ns/1ps
`default_nettype none

module controller_router (
  input  logic                          clk_74a,
  input  logic                          pll_core_locked,
  input  pce_ctrl_pkg::analogizer_cfg_t analog_cfg,
  input  pce_ctrl_pkg::pad_keys_t       cont_keys,
  input  pce_ctrl_pkg::pad_keys_t       snac_pads,
  output pce_ctrl_pkg::pad_keys_t       player_controls
);

  pce_ctrl_pkg::pad_keys_t routed;

  //////////////////////////////
  // source select
  //////////////////////////////

  always_comb begin
    // default is the handheld's own pads
    routed = cont_keys;
    if (analog_cfg.game_cont_type != '0) begin
      case (analog_cfg.cont_assignment)
        pce_ctrl_pkg::assign_p1: begin
          routed.p1 = snac_pads.p1;
        end
        pce_ctrl_pkg::assign_p2: begin
          routed.p2 = snac_pads.p1;
        end
        pce_ctrl_pkg::assign_p1p2: begin
          routed.p1 = snac_pads.p1;
          routed.p2 = snac_pads.p2;
        end
        // snac ports crossed over
        pce_ctrl_pkg::assign_swap: begin
          routed.p1 = snac_pads.p2;
          routed.p2 = snac_pads.p1;
        end
        // multitap, all four from snac
        pce_ctrl_pkg::assign_all: begin
          routed = snac_pads;
        end
        pce_ctrl_pkg::assign_reverse: begin
          routed.p1 = snac_pads.p4;
          routed.p2 = snac_pads.p3;
          routed.p3 = snac_pads.p2;
          routed.p4 = snac_pads.p1;
        end
        // snac feeds the upper two players
        pce_ctrl_pkg::assign_p3p4: begin
          routed.p3 = snac_pads.p1;
          routed.p4 = snac_pads.p2;
        end
        default: begin
          routed = cont_keys;
        end
      endcase
    end
  end

  // one register stage into the core
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      player_controls <= '0;
    end else begin
      player_controls <= routed;
    end
  end

  // snac off means plain pass-through, one cycle late
  a_snac_off_passthrough : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    (analog_cfg.game_cont_type == '0) |=> (player_controls == $past(cont_keys))
  );

endmodule

`default_nettype wire

//--- core_reset_fsm.sv
// core reset state machine
// holds the core in reset during host reset and for a timed
// hold after each bridge reset request

`timescale 1ns/1ps
`default_nettype none

module core_reset_fsm (
  input  logic clk_74a,
  input  logic pll_core_locked,
  input  logic host_reset_n,
  input  logic reset_request,
  input  logic hold_done,
  output logic hold_load,
  output logic core_reset
);

  pce_ctrl_pkg::reset_state_e state;
  pce_ctrl_pkg::reset_state_e state_next;

  // requests only count once the host has released reset
  assign hold_load = reset_request && host_reset_n &&
                     (state != pce_ctrl_pkg::st_host_reset);

  //////////////////////////////
  // next state
  //////////////////////////////

  always_comb begin
    state_next = state;
    if (!host_reset_n) begin
      // host reset beats everything
      state_next = pce_ctrl_pkg::st_host_reset;
    end else begin
      case (state)
        pce_ctrl_pkg::st_host_reset:
          state_next = pce_ctrl_pkg::st_run;
        pce_ctrl_pkg::st_run:
          if (reset_request) state_next = pce_ctrl_pkg::st_hold;
        pce_ctrl_pkg::st_hold:
          // a new request restarts the hold
          if (!reset_request && hold_done) state_next = pce_ctrl_pkg::st_run;
        default:
          state_next = pce_ctrl_pkg::st_host_reset;
      endcase
    end
  end

  // core_reset registered with the state, low only in run
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      state      <= pce_ctrl_pkg::st_host_reset;
      core_reset <= 1'b1;
    end else begin
      state      <= state_next;
      core_reset <= (state_next != pce_ctrl_pkg::st_run);
    end
  end

  // host reset reaches the core within one edge
  a_host_reset_to_core : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    !host_reset_n |=> core_reset
  );

endmodule

`default_nettype wire

//--- pce_core_ctrl.sv
// pce core control plane top
// bridge settings registers, core reset sequencing and
// player pad routing, all on the bridge clock

`timescale 1ns/1ps
`default_nettype none

module pce_core_ctrl (
  input  logic                         clk_74a,
  input  logic                         pll_core_locked,
  input  logic                         host_reset_n,
  input  logic                         bridge_wr,
  input  logic [31:0]                  bridge_addr,
  input  logic [31:0]                  bridge_wr_data,
  output logic [31:0]                  bridge_rd_data,
  input  pce_ctrl_pkg::pad_keys_t      cont_keys,
  input  pce_ctrl_pkg::pad_keys_t      snac_pads,
  output pce_ctrl_pkg::pad_keys_t      player_controls,
  output pce_ctrl_pkg::core_settings_t settings,
  output logic                         core_reset
);

  pce_ctrl_pkg::analogizer_cfg_t analog_cfg;
  logic                          reset_request;
  logic                          hold_load;
  logic                          hold_done;

  //////////////////////////////
  // bridge side
  //////////////////////////////

  bridge_settings_regs u_bridge_settings_regs (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_addr     (bridge_addr),
    .bridge_wr_data  (bridge_wr_data),
    .bridge_wr       (bridge_wr),
    .bridge_rd_data  (bridge_rd_data),
    .settings        (settings),
    .analog_cfg      (analog_cfg),
    .reset_request   (reset_request)
  );

  //////////////////////////////
  // core reset
  //////////////////////////////

  core_reset_fsm u_core_reset_fsm (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .host_reset_n    (host_reset_n),
    .reset_request   (reset_request),
    .hold_done       (hold_done),
    .hold_load       (hold_load),
    .core_reset      (core_reset)
  );

  reset_hold_timer u_reset_hold_timer (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .hold_load       (hold_load),
    .hold_done       (hold_done)
  );

  // pads into the core
  controller_router u_controller_router (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .analog_cfg      (analog_cfg),
    .cont_keys       (cont_keys),
    .snac_pads       (snac_pads),
    .player_controls (player_controls)
  );

endmodule

`default_nettype wire

//--- pce_ctrl_pkg.sv
// pce core control package
// shared types for the bridge settings registers, the core reset
// state machine and the player pad routing

`default_nettype none

package pce_ctrl_pkg;

  //////////////////////////////
  // timing constants
  //////////////////////////////

  // hold timer width, wide enough for the load value itself
  localparam int HOLD_COUNT_W = 9;

  // core reset hold after a host reset request
  localparam logic [HOLD_COUNT_W-1:0] RESET_HOLD_CYCLES = 9'd256;

  //////////////////////////////
  // pad words
  //////////////////////////////

  // one 16-bit key word per player
  // [0] up [1] down [2] left [3] right
  // [4] a [5] b [6] x [7] y
  // [8] l1 [9] r1 [10] l2 [11] r2
  // [12] l3 [13] r3 [14] select [15] start
  typedef struct packed {
    logic [15:0] p1;
    logic [15:0] p2;
    logic [15:0] p3;
    logic [15:0] p4;
  } pad_keys_t;

  //////////////////////////////
  // settings
  //////////////////////////////

  // settings handed to the emulator core
  typedef struct packed {
    logic       turbo_tap_enable;
    logic       button6_enable;
    logic [1:0] button1_turbo_speed;
    logic [1:0] button2_turbo_speed;
    logic       overscan_enable;
    logic       extra_sprites_enable;
    logic       raw_rgb_enable;
    logic       cd_audio_boost;
    logic       adpcm_audio_boost;
    logic [1:0] master_audio_boost;
    logic       is_sgx;
  } core_settings_t;

  // analogizer settings word, 14 bits as written by the host
  // game_cont_type of zero turns SNAC off
  typedef struct packed {
    logic [3:0] video_type;
    logic [3:0] cont_assignment;
    logic       reserved;
    logic [4:0] game_cont_type;
  } analogizer_cfg_t;

  //////////////////////////////
  // bridge register map
  //////////////////////////////

  typedef enum logic [31:0] {
    reg_sgx           = 32'h0000_0008,
    reg_reset         = 32'h0000_0050,
    reg_turbo_tap     = 32'h0000_0100,
    reg_button6       = 32'h0000_0104,
    reg_b1_speed      = 32'h0000_0108,
    reg_b2_speed      = 32'h0000_010C,
    reg_overscan      = 32'h0000_0200,
    reg_extra_sprites = 32'h0000_0204,
    reg_raw_rgb       = 32'h0000_0208,
    reg_master_boost  = 32'h0000_0300,
    reg_adpcm_boost   = 32'h0000_0304,
    reg_cd_boost      = 32'h0000_0308,
    reg_analogizer    = 32'hF700_0000
  } bridge_reg_e;

  // snac to player mapping codes
  typedef enum logic [3:0] {
    assign_p1      = 4'd0,
    assign_p2      = 4'd1,
    assign_p1p2    = 4'd2,
    assign_swap    = 4'd3,
    assign_all     = 4'd4,
    assign_reverse = 4'd5,
    assign_p3p4    = 4'd6
  } snac_assign_e;

  // core reset sequencing
  typedef enum logic [1:0] {
    st_host_reset,
    st_hold,
    st_run
  } reset_state_e;

endpackage

`default_nettype wire

//--- reset_hold_timer.sv
// core reset hold timer
// down-counter loaded on a hold request, done while at zero

`timescale 1ns/1ps
`default_nettype none

module reset_hold_timer (
  input  logic clk_74a,
  input  logic pll_core_locked,
  input  logic hold_load,
  output logic hold_done
);

  logic [pce_ctrl_pkg::HOLD_COUNT_W-1:0] count;

  // load wins over the decrement
  // parks at zero until the next load
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      count <= '0;
    end else if (hold_load) begin
      count <= pce_ctrl_pkg::RESET_HOLD_CYCLES;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // level, high whenever no hold is running
  assign hold_done = (count == '0);

  // count stays inside the load range
  a_count_range : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    count <= pce_ctrl_pkg::RESET_HOLD_CYCLES
  );

endmodule

`default_nettype wire

//--- src.f
+incdir+.
pce_ctrl_pkg.sv
bridge_settings_regs.sv
reset_hold_timer.sv
core_reset_fsm.sv
controller_router.sv
pce_core_ctrl.sv
tb_pce_core_ctrl.sv

//--- tb_pce_core_ctrl_tests.svh
// pce core control directed tests
// reset state, settings writes, analogizer readback, pad routing
// and the core reset hold sequence

`ifndef TB_PCE_CORE_CTRL_TESTS_SVH
`define TB_PCE_CORE_CTRL_TESTS_SVH

  // expected pad routing per assignment code
  // sources 0..3 are own pads p1..p4 and 4..7 are snac p1..p4
  function automatic pce_ctrl_pkg::pad_keys_t routed_pads(input int code,
      input pce_ctrl_pkg::pad_keys_t own, input pce_ctrl_pkg::pad_keys_t snac);
    int                      src [4];
    logic [15:0]             words [8];
    pce_ctrl_pkg::pad_keys_t result;
    words = '{own.p1, own.p2, own.p3, own.p4, snac.p1, snac.p2, snac.p3, snac.p4};
    case (code)
      0: src = '{4, 1, 2, 3};
      1: src = '{0, 4, 2, 3};
      2: src = '{4, 5, 2, 3};
      3: src = '{5, 4, 2, 3};
      4: src = '{4, 5, 6, 7};
      5: src = '{7, 6, 5, 4};
      6: src = '{0, 1, 4, 5};
      default: src = '{0, 1, 2, 3};
    endcase
    result.p1 = words[src[0]];
    result.p2 = words[src[1]];
    result.p3 = words[src[2]];
    result.p4 = words[src[3]];
    return result;
  endfunction

  task automatic reset_state_test();
    logic [31:0] rd;
    start_test("reset_state");
    check_value("core_reset", 64'd1, core_reset);
    check_value("settings", 64'd0, settings);
    bridge_read(pce_ctrl_pkg::reg_analogizer, rd);
    check_value("analogizer readback", 64'd0, rd);
    check_value("player_controls", 64'd0, player_controls);
    end_test();
  endtask

  task automatic settings_write_test();
    pce_ctrl_pkg::bridge_reg_e    addr_list [11];
    pce_ctrl_pkg::core_settings_t expected;
    logic [31:0]                  data;
    logic [31:0]                  rd_after;
    start_test("settings_writes");
    addr_list = '{pce_ctrl_pkg::reg_sgx, pce_ctrl_pkg::reg_turbo_tap,
                  pce_ctrl_pkg::reg_button6, pce_ctrl_pkg::reg_b1_speed,
                  pce_ctrl_pkg::reg_b2_speed, pce_ctrl_pkg::reg_overscan,
                  pce_ctrl_pkg::reg_extra_sprites, pce_ctrl_pkg::reg_raw_rgb,
                  pce_ctrl_pkg::reg_master_boost, pce_ctrl_pkg::reg_adpcm_boost,
                  pce_ctrl_pkg::reg_cd_boost};
    expected = '0;
    foreach (addr_list[i]) begin
      data = $urandom;
      bridge_write(addr_list[i], data);
      // flags keep bit 0 while speeds and master boost keep two bits
      case (addr_list[i])
        pce_ctrl_pkg::reg_sgx:           expected.is_sgx = data[0];
        pce_ctrl_pkg::reg_turbo_tap:     expected.turbo_tap_enable = data[0];
        pce_ctrl_pkg::reg_button6:       expected.button6_enable = data[0];
        pce_ctrl_pkg::reg_b1_speed:      expected.button1_turbo_speed = data[1:0];
        pce_ctrl_pkg::reg_b2_speed:      expected.button2_turbo_speed = data[1:0];
        pce_ctrl_pkg::reg_overscan:      expected.overscan_enable = data[0];
        pce_ctrl_pkg::reg_extra_sprites: expected.extra_sprites_enable = data[0];
        pce_ctrl_pkg::reg_raw_rgb:       expected.raw_rgb_enable = data[0];
        pce_ctrl_pkg::reg_master_boost:  expected.master_audio_boost = data[1:0];
        pce_ctrl_pkg::reg_adpcm_boost:   expected.adpcm_audio_boost = data[0];
        default:                         expected.cd_audio_boost = data[0];
      endcase
      check_value($sformatf("settings after write to %h", addr_list[i]), expected, settings);
    end
    // unlisted addresses must leave everything alone
    bridge_write(32'h0000_0054, 32'hFFFF_FFFF);
    bridge_write(32'h0000_0004, $urandom);
    bridge_write(32'hF700_0004, $urandom);
    check_value("settings after unlisted writes", expected, settings);
    // analogizer word has not been written since reset
    bridge_read(pce_ctrl_pkg::reg_analogizer, rd_after);
    check_value("analogizer after unlisted writes", 64'd0, rd_after);
    end_test();
  endtask

  task automatic analogizer_readback_test();
    logic [31:0] other_addr [5];
    logic [31:0] data;
    logic [31:0] rd;
    start_test("analogizer_readback");
    other_addr = '{pce_ctrl_pkg::reg_sgx, pce_ctrl_pkg::reg_reset,
                   pce_ctrl_pkg::reg_b1_speed, 32'hF700_0004, 32'h0000_0000};
    data = $urandom;
    bridge_write(pce_ctrl_pkg::reg_analogizer, data);
    bridge_read(pce_ctrl_pkg::reg_analogizer, rd);
    check_value("analogizer readback", {18'd0, data[13:0]}, rd);
    foreach (other_addr[i]) begin
      bridge_read(other_addr[i], rd);
      check_value($sformatf("readback at %h", other_addr[i]), 64'd0, rd);
    end
    end_test();
  endtask

  task automatic routing_test();
    logic [4:0] cont_type;
    logic [3:0] video;
    logic       spare;
    start_test("routing");
    // snac off ignores the assignment code
    bridge_write(pce_ctrl_pkg::reg_analogizer, {18'd0, 4'd0, 4'd4, 1'b0, 5'd0});
    repeat (4) begin
      @(posedge clk_74a);
      #1;
      cont_keys = {$urandom, $urandom};
      snac_pads = {$urandom, $urandom};
      @(posedge clk_74a);
      #1;
      check_value("snac off pass-through", cont_keys, player_controls);
    end
    // every assignment code with snac on
    for (int code = 0; code < 16; code++) begin
      cont_type = 5'($urandom_range(31, 1));
      video     = 4'($urandom);
      spare     = 1'($urandom);
      bridge_write(pce_ctrl_pkg::reg_analogizer,
                   {18'd0, video, 4'(code), spare, cont_type});
      cont_keys = {$urandom, $urandom};
      snac_pads = {$urandom, $urandom};
      @(posedge clk_74a);
      #1;
      check_value($sformatf("code %0d", code), routed_pads(code, cont_keys, snac_pads),
                  player_controls);
    end
    end_test();
  endtask

  task automatic reset_hold_test();
    int hold_len;
    int host_edge;
    int rise;
    int fall;
    start_test("reset_hold");
    hold_len = int'(pce_ctrl_pkg::RESET_HOLD_CYCLES) + 1;
    // core runs one edge after the host releases
    @(posedge clk_74a);
    #1;
    host_reset_n = 1'b1;
    host_edge    = cycle_count;
    wait_core_reset(1'b0, 8, fall);
    check_value("release edge", host_edge + 1, fall);
    // plain hold after a reset write
    bridge_write(pce_ctrl_pkg::reg_reset, $urandom);
    check_value("core_reset right after write", 64'd0, core_reset);
    wait_core_reset(1'b1, 8, rise);
    check_value("hold start edge", last_write_edge + 1, rise);
    wait_core_reset(1'b0, hold_len * 2, fall);
    check_value("hold length", hold_len, fall - rise);
    // retrigger part way in
    bridge_write(pce_ctrl_pkg::reg_reset, $urandom);
    wait_core_reset(1'b1, 8, rise);
    repeat (hold_len / 2) @(posedge clk_74a);
    bridge_write(pce_ctrl_pkg::reg_reset, $urandom);
    check_value("core_reset mid hold", 64'd1, core_reset);
    wait_core_reset(1'b0, hold_len * 2, fall);
    check_value("extended hold end", last_write_edge + hold_len + 1, fall);
    check_value("hold extended", 64'd1, (fall - rise) > hold_len);
    // host reset again
    @(posedge clk_74a);
    #1;
    host_reset_n = 1'b0;
    host_edge    = cycle_count;
    wait_core_reset(1'b1, 8, rise);
    check_value("host reset edge", host_edge + 1, rise);
    end_test();
  endtask

`endif

//--- tb_pce_core_ctrl.sv
// pce core control testbench
// clock, reset and bridge access around the control plane top,
// runs the directed tests and prints the run summary

`timescale 1ns/1ps
`default_nettype none

module tb_pce_core_ctrl;

  logic                         clk_74a;
  logic                         pll_core_locked;
  logic                         host_reset_n;
  logic                         bridge_wr;
  logic [31:0]                  bridge_addr;
  logic [31:0]                  bridge_wr_data;
  logic [31:0]                  bridge_rd_data;
  pce_ctrl_pkg::pad_keys_t      cont_keys;
  pce_ctrl_pkg::pad_keys_t      snac_pads;
  pce_ctrl_pkg::pad_keys_t      player_controls;
  pce_ctrl_pkg::core_settings_t settings;
  logic                         core_reset;

  // run bookkeeping
  int          cycle_count = 0;
  int          last_write_edge;
  int          check_count;
  int          error_count;
  int          test_count;
  int          test_errors_at_start;
  string       current_test;
  int unsigned seed_value;

  pce_core_ctrl u_pce_core_ctrl (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .host_reset_n    (host_reset_n),
    .bridge_wr       (bridge_wr),
    .bridge_addr     (bridge_addr),
    .bridge_wr_data  (bridge_wr_data),
    .bridge_rd_data  (bridge_rd_data),
    .cont_keys       (cont_keys),
    .snac_pads       (snac_pads),
    .player_controls (player_controls),
    .settings        (settings),
    .core_reset      (core_reset)
  );

  //////////////////////////////
  // clock and edge counter
  //////////////////////////////

  // 20 ns period
  initial clk_74a = 1'b0;
  always #10 clk_74a = ~clk_74a;

  // edge number as seen 1 ns after each edge
  always @(posedge clk_74a) cycle_count <= cycle_count + 1;

  //////////////////////////////
  // bridge access
  //////////////////////////////

  // one strobe cycle that returns 1 ns after the sampling edge
  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_74a);
    #1;
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    @(posedge clk_74a);
    #1;
    bridge_wr       = 1'b0;
    last_write_edge = cycle_count;
  endtask

  // combinational read data sampled 2 ns after the address settles
  task automatic bridge_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk_74a);
    #1;
    bridge_addr = addr;
    #2;
    data = bridge_rd_data;
  endtask

  //////////////////////////////
  // checking helpers
  //////////////////////////////

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count++;
    assert (actual === expected) else begin
      $display("[FAIL] %s %s expected %h actual %h", current_test, what, expected, actual);
      error_count++;
    end
  endtask

  task automatic start_test(input string name);
    current_test         = name;
    test_errors_at_start = error_count;
    test_count++;
  endtask

  task automatic end_test();
    if (error_count == test_errors_at_start) begin
      $display("test %s passed", current_test);
    end else begin
      $display("test %s failed with %0d errors", current_test,
               error_count - test_errors_at_start);
    end
  endtask

  // bounded wait for core_reset to show a level after an edge
  task automatic wait_core_reset(input logic level, input int limit, output int edge_num);
    int waited;
    waited   = 0;
    edge_num = -1;
    while (edge_num < 0 && waited < limit) begin
      @(posedge clk_74a);
      #1;
      waited++;
      if (core_reset === level) edge_num = cycle_count;
    end
    assert (edge_num >= 0) else begin
      $display("%s: timed out after %0d cycles waiting for core_reset to go %0b",
               current_test, limit, level);
      error_count++;
    end
  endtask

  `include "tb_pce_core_ctrl_tests.svh"

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    pll_core_locked = 1'b0;
    host_reset_n    = 1'b0;
    bridge_wr       = 1'b0;
    bridge_addr     = '0;
    bridge_wr_data  = '0;
    cont_keys       = '0;
    snac_pads       = '0;
    check_count     = 0;
    error_count     = 0;
    test_count      = 0;
    seed_value      = $urandom(52060);
    // two cycles of reset
    repeat (2) @(posedge clk_74a);
    #1;
    pll_core_locked = 1'b1;
    reset_state_test();
    settings_write_test();
    analogizer_readback_test();
    routing_test();
    reset_hold_test();
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
